// File: compile.f
+incdir+logic
logic/reg_bus_pkg.sv
logic/reg_int_file.sv
logic/reg_addr_decoder.sv
logic/reg_slv_fsm.sv
logic/reg_slv_if.sv
tests/ext_reg_bfm.sv
tests/reg_slv_if_tb.sv

// File: Bender.yml
package:
  name: reg_slv_if

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/reg_bus_pkg.sv
      - logic/reg_int_file.sv
      - logic/reg_addr_decoder.sv
      - logic/reg_slv_fsm.sv
      - logic/reg_slv_if.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/ext_reg_bfm.sv
      - tests/reg_slv_if_tb.sv

// File: tests/reg_slv_if_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "reg_bus_cfg.svh"

module reg_slv_if_tb;

    localparam int AW        = `REG_ADDR_W;
    localparam int DW        = `REG_DATA_W;
    localparam int N_EXT     = `REG_NUM_EXT;
    localparam int N_INT     = `REG_NUM_INT_REGS;
    localparam int EXT_WORDS = 16;
    localparam int TGT_VALS  = 1 << (`REG_ADDR_W - `REG_TGT_LSB);
    localparam int MODE_RAND = 0;
    localparam int MODE_WR   = 1;
    localparam int MODE_RD   = 2;
    // transaction count over all tests for the watchdog
    localparam int TXN_TOTAL = 200 + 200 + 20 + 30 + 25;
    localparam int TIMEOUT_NS = 40 * TXN_TOTAL * 10;

    logic                  clk;
    logic                  rstn;
    reg_bus_pkg::reg_req_t mst_req;
    logic                  mst_req_vld;
    logic                  mst_req_rdy;
    reg_bus_pkg::reg_rsp_t mst_rsp;
    logic                  mst_ack_vld;
    logic                  mst_ack_rdy;
    logic                  mst_sync_reset;
    reg_bus_pkg::reg_req_t ext_req;
    logic [N_EXT-1:0]      ext_req_vld;
    wire  [N_EXT-1:0]      ext_req_rdy;
    wire  [N_EXT-1:0]      ext_ack_vld;
    logic [N_EXT-1:0]      ext_ack_rdy;
    wire  [DW-1:0]         ext_rdata [N_EXT];
    logic                  ext_sync_reset;

    // reference model with one word array per target
    logic [DW-1:0] int_model [N_INT];
    logic [DW-1:0] ext_model [N_EXT][EXT_WORDS];
    // bus monitor counts
    int ext_acc [N_EXT];
    int ext_ack [N_EXT];
    int ext_expect [N_EXT];
    int ext_vld_cycles;
    int sync_seen;
    logic [31:0] rand_state;
    int n_checks;
    int n_errors;
    int mark_checks;
    int mark_errors;
    int mark;

    reg_slv_if dut0 (
        .clk            (clk),
        .rstn           (rstn),
        .mst_req        (mst_req),
        .mst_req_vld    (mst_req_vld),
        .mst_req_rdy    (mst_req_rdy),
        .mst_rsp        (mst_rsp),
        .mst_ack_vld    (mst_ack_vld),
        .mst_ack_rdy    (mst_ack_rdy),
        .mst_sync_reset (mst_sync_reset),
        .ext_req        (ext_req),
        .ext_req_vld    (ext_req_vld),
        .ext_req_rdy    (ext_req_rdy),
        .ext_ack_vld    (ext_ack_vld),
        .ext_ack_rdy    (ext_ack_rdy),
        .ext_rdata      (ext_rdata),
        .ext_sync_reset (ext_sync_reset)
    );

    for (genvar i = 0; i < N_EXT; i++) begin : g_ext
        ext_reg_bfm #(.SEED_OFS(i + 1)) bfm (
            .clk        (clk),
            .rstn       (rstn),
            .sync_reset (ext_sync_reset),
            .req        (ext_req),
            .req_vld    (ext_req_vld[i]),
            .req_rdy    (ext_req_rdy[i]),
            .ack_vld    (ext_ack_vld[i]),
            .ack_rdy    (ext_ack_rdy[i]),
            .rdata      (ext_rdata[i])
        );
    end

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // per-block handshake counts
    always @(posedge clk) begin
        for (int i = 0; i < N_EXT; i++) begin
            if (ext_req_vld[i]) ext_vld_cycles++;
            if (ext_req_vld[i] && ext_req_rdy[i]) ext_acc[i]++;
            if (ext_ack_vld[i] && ext_ack_rdy[i]) ext_ack[i]++;
        end
        if (ext_sync_reset) sync_seen++;
    end

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    // low LCG bits have short periods so the upper ones are taken
    function automatic int rand_below(input int n);
        return int'((next_rand() >> 16) % n);
    endfunction

    function automatic int rand_word(input int field);
        return rand_below((field == 0) ? N_INT : EXT_WORDS);
    endfunction

    function automatic reg_bus_pkg::reg_tgt_e target_of(input int field);
        reg_bus_pkg::reg_tgt_e t;
        if (field == 0) t = reg_bus_pkg::TGT_INT;
        else if (field <= N_EXT) t = reg_bus_pkg::TGT_EXT;
        else t = reg_bus_pkg::TGT_NONE;
        return t;
    endfunction

    function automatic logic [AW-1:0] make_addr(input int field, input int word, input int byt);
        logic [AW-1:0] a;
        a = AW'(field) << `REG_TGT_LSB;
        a = a | (AW'(word) << `REG_WORD_LSB) | AW'(byt & 3);
        return a;
    endfunction

    function automatic reg_bus_pkg::reg_req_t make_req(input reg_bus_pkg::reg_op_e op,
                                                       input logic [AW-1:0] addr,
                                                       input logic [DW-1:0] wdata);
        reg_bus_pkg::reg_req_t r;
        r.op    = op;
        r.addr  = addr;
        r.wdata = wdata;
        return r;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        n_checks++;
        if (exp !== act) begin
            n_errors++;
            $display("error at %0t: %s expected 0x%0h got 0x%0h", $time, name, exp, act);
        end
    endtask

    task automatic start_test();
        mark_checks = n_checks;
        mark_errors = n_errors;
    endtask

    task automatic end_test(input int num, input string name);
        $display("test %0d %s: %0d checks, %0d errors", num, name,
                 n_checks - mark_checks, n_errors - mark_errors);
    endtask

    // one master transaction with ack ready held low for stall cycles of ack valid
    task automatic run_txn(input reg_bus_pkg::reg_op_e op, input logic [AW-1:0] addr,
                           input logic [DW-1:0] wdata, input int stall,
                           output reg_bus_pkg::reg_rsp_t rsp);
        int low_cycles;
        bit seen;
        reg_bus_pkg::reg_rsp_t first;
        low_cycles = 0;
        seen = 1'b0;
        first = '0;
        mst_req     <= make_req(op, addr, wdata);
        mst_req_vld <= 1'b1;
        mst_ack_rdy <= (stall == 0);
        @(posedge clk);
        while (!mst_req_rdy) @(posedge clk);
        mst_req_vld <= 1'b0;
        forever begin
            @(posedge clk);
            // no new acceptance until the ack completes
            check_value("mst_req_rdy", 0, mst_req_rdy);
            if (mst_ack_vld) begin
                if (!seen) begin
                    first = mst_rsp;
                    seen = 1'b1;
                end
                check_value("mst_rsp.rdata", first.rdata, mst_rsp.rdata);
                check_value("mst_rsp.err", first.err, mst_rsp.err);
                if (mst_ack_rdy) break;
                low_cycles++;
                if (low_cycles >= stall) mst_ack_rdy <= 1'b1;
            end else if (seen) begin
                // ack valid has to hold until the master takes it
                check_value("mst_ack_vld", 1, mst_ack_vld);
            end
        end
        rsp = first;
        mst_ack_rdy <= 1'b0;
        @(posedge clk);
        // single ack and ready again
        check_value("mst_ack_vld", 0, mst_ack_vld);
        check_value("mst_req_rdy", 1, mst_req_rdy);
    endtask

    // access plus model update and response check
    task automatic access(input int field, input int mode, input int word, input int stall);
        reg_bus_pkg::reg_op_e op;
        reg_bus_pkg::reg_rsp_t rsp;
        logic [31:0] r;
        logic [DW-1:0] wdata;
        int blk;
        r = next_rand();
        wdata = next_rand();
        if (mode == MODE_WR) op = reg_bus_pkg::OP_WRITE;
        else if (mode == MODE_RD) op = reg_bus_pkg::OP_READ;
        else op = r[20] ? reg_bus_pkg::OP_WRITE : reg_bus_pkg::OP_READ;
        run_txn(op, make_addr(field, word, int'(r[1:0])), wdata, stall, rsp);
        case (target_of(field))
            reg_bus_pkg::TGT_INT: begin
                if (op == reg_bus_pkg::OP_WRITE) int_model[word] = wdata;
                else check_value("mst_rsp.rdata", int_model[word], rsp.rdata);
                check_value("mst_rsp.err", 0, rsp.err);
            end
            reg_bus_pkg::TGT_EXT: begin
                blk = field - 1;
                ext_expect[blk]++;
                if (op == reg_bus_pkg::OP_WRITE) ext_model[blk][word] = wdata;
                else check_value("mst_rsp.rdata", ext_model[blk][word], rsp.rdata);
                check_value("mst_rsp.err", 0, rsp.err);
            end
            default: begin
                check_value("mst_rsp.err", 1, rsp.err);
                check_value("mst_rsp.rdata", 0, rsp.rdata);
            end
        endcase
    endtask

    task automatic clear_model();
        for (int i = 0; i < N_INT; i++) int_model[i] = '0;
        for (int b = 0; b < N_EXT; b++) begin
            for (int i = 0; i < EXT_WORDS; i++) ext_model[b][i] = '0;
        end
    endtask

    initial begin
        int field;
        rand_state     = 32'hdf8b_e9c9;
        n_checks       = 0;
        n_errors       = 0;
        rstn           = 1'b0;
        mst_req        = '0;
        mst_req_vld    = 1'b0;
        mst_ack_rdy    = 1'b0;
        mst_sync_reset = 1'b0;
        clear_model();

        start_test();
        @(posedge clk);
        @(posedge clk);
        // outputs sampled just before the second reset edge
        check_value("mst_req_rdy", 0, mst_req_rdy);
        check_value("mst_ack_vld", 0, mst_ack_vld);
        rstn <= 1'b1;
        @(posedge clk);
        @(posedge clk);
        check_value("mst_req_rdy", 1, mst_req_rdy);
        end_test(1, "reset state");

        start_test();
        repeat (200) access(0, MODE_RAND, rand_word(0), rand_below(3));
        end_test(2, "internal file");

        start_test();
        repeat (200) begin
            field = 1 + rand_below(N_EXT);
            access(field, MODE_RAND, rand_word(field), rand_below(3));
        end
        for (int i = 0; i < N_EXT; i++) begin
            check_value("ext_acc", ext_expect[i], ext_acc[i]);
            check_value("ext_ack", ext_expect[i], ext_ack[i]);
        end
        end_test(3, "external blocks");

        start_test();
        mark = ext_vld_cycles;
        repeat (20) begin
            field = N_EXT + 1 + rand_below(TGT_VALS - N_EXT - 1);
            access(field, MODE_RAND, rand_below(EXT_WORDS), rand_below(3));
        end
        // unmapped requests never reach a block
        check_value("ext_req_vld cycles", mark, ext_vld_cycles);
        end_test(4, "unmapped");

        start_test();
        repeat (30) begin
            field = rand_below(N_EXT + 2);
            access(field, MODE_RAND, rand_word(field), 2);
        end
        end_test(5, "back-pressure");

        start_test();
        for (int w = 0; w < 4; w++) begin
            for (int f = 0; f <= N_EXT; f++) access(f, MODE_WR, w, 0);
        end
        // read left outstanding across the pulse
        mark = sync_seen;
        mst_req     <= make_req(reg_bus_pkg::OP_READ, make_addr(1, 1, 0), '0);
        mst_req_vld <= 1'b1;
        @(posedge clk);
        while (!mst_req_rdy) @(posedge clk);
        mst_req_vld    <= 1'b0;
        @(posedge clk);
        mst_sync_reset <= 1'b1;
        @(posedge clk);
        check_value("mst_ack_vld", 0, mst_ack_vld);
        mst_sync_reset <= 1'b0;
        mst_ack_rdy    <= 1'b1;
        repeat (8) begin
            @(posedge clk);
            check_value("mst_ack_vld", 0, mst_ack_vld);
        end
        check_value("ext_sync_reset cycles", 1, sync_seen - mark);
        clear_model();
        for (int w = 0; w < 4; w++) begin
            for (int f = 0; f <= N_EXT; f++) access(f, MODE_RD, w, 0);
        end
        end_test(6, "soft reset");

        $display("summary: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/ext_reg_bfm.sv
`timescale 1ns/1ps
`default_nettype none

`include "reg_bus_cfg.svh"

module ext_reg_bfm #(
    parameter int SEED_OFS = 0
) (
    input  wire                        clk,
    input  wire                        rstn,
    input  wire                        sync_reset,
    input  wire reg_bus_pkg::reg_req_t req,
    input  wire                        req_vld,
    output logic                       req_rdy,
    output logic                       ack_vld,
    input  wire                        ack_rdy,
    output logic [`REG_DATA_W-1:0]     rdata
);

    logic [`REG_DATA_W-1:0] mem [16];
    logic [31:0]            rnd;
    logic                   busy;
    logic [1:0]             rdy_wait;
    logic [2:0]             ack_wait;
    logic [3:0]             idx;
    logic                   accept;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    assign idx     = req.addr[`REG_WORD_LSB +: 4];
    // ready only when idle and the random wait has run out
    assign req_rdy = ~busy & (rdy_wait == 2'd0);
    assign accept  = req_vld & req_rdy;

    always @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rnd      <= 32'hdf8b_e9c9 ^ (SEED_OFS * 32'h9e37_79b9);
            busy     <= 1'b0;
            ack_vld  <= 1'b0;
            rdy_wait <= 2'd0;
            ack_wait <= 3'd1;
            rdata    <= '0;
            for (int i = 0; i < 16; i++) begin
                mem[i] <= '0;
            end
        end else if (sync_reset) begin
            // soft reset drops any pending access and clears the words
            busy    <= 1'b0;
            ack_vld <= 1'b0;
            for (int i = 0; i < 16; i++) begin
                mem[i] <= '0;
            end
        end else if (accept) begin
            rnd      <= lcg_next(rnd);
            busy     <= 1'b1;
            // 1 to 4 cycles until ack
            ack_wait <= 3'd1 + {1'b0, rnd[17:16]};
            if (req.op == reg_bus_pkg::OP_WRITE) begin
                mem[idx] <= req.wdata;
                rdata    <= req.wdata;
            end else begin
                rdata <= mem[idx];
            end
        end else if (busy && !ack_vld) begin
            if (ack_wait == 3'd1) begin
                ack_vld <= 1'b1;
            end else begin
                ack_wait <= ack_wait - 3'd1;
            end
        end else if (ack_vld && ack_rdy) begin
            ack_vld  <= 1'b0;
            busy     <= 1'b0;
            rnd      <= lcg_next(rnd);
            // 0 to 3 cycles before the next req ready
            rdy_wait <= rnd[21:20];
        end else if (!busy && req_vld && rdy_wait != 2'd0) begin
            rdy_wait <= rdy_wait - 2'd1;
        end
    end

endmodule

`default_nettype wire

// File: logic/reg_slv_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "reg_bus_cfg.svh"

module reg_slv_if (
    input  wire                        clk,
    input  wire                        rstn,
    // master port
    input  wire reg_bus_pkg::reg_req_t mst_req,
    input  wire                        mst_req_vld,
    output logic                       mst_req_rdy,
    output reg_bus_pkg::reg_rsp_t      mst_rsp,
    output logic                       mst_ack_vld,
    input  wire                        mst_ack_rdy,
    input  wire                        mst_sync_reset,
    // external register blocks
    output reg_bus_pkg::reg_req_t      ext_req,
    output logic [`REG_NUM_EXT-1:0]    ext_req_vld,
    input  wire [`REG_NUM_EXT-1:0]     ext_req_rdy,
    input  wire [`REG_NUM_EXT-1:0]     ext_ack_vld,
    output logic [`REG_NUM_EXT-1:0]    ext_ack_rdy,
    input  wire [`REG_DATA_W-1:0]      ext_rdata [`REG_NUM_EXT],
    output logic                       ext_sync_reset
);

    // FSM to decoder
    reg_bus_pkg::reg_req_t  slv_req;
    logic                   slv_req_vld;
    logic                   slv_req_rdy;
    reg_bus_pkg::reg_rsp_t  slv_rsp;
    logic                   slv_ack_vld;
    logic                   slv_ack_rdy;
    logic                   sync_reset;
    // decoder to internal file
    logic                   int_req_vld;
    logic                   int_req_rdy;
    logic                   int_ack_vld;
    logic                   int_ack_rdy;
    logic [`REG_DATA_W-1:0] int_rdata;

    reg_slv_fsm fsm0 (
        .clk            (clk),
        .rstn           (rstn),
        .mst_req        (mst_req),
        .mst_req_vld    (mst_req_vld),
        .mst_req_rdy    (mst_req_rdy),
        .mst_rsp        (mst_rsp),
        .mst_ack_vld    (mst_ack_vld),
        .mst_ack_rdy    (mst_ack_rdy),
        .mst_sync_reset (mst_sync_reset),
        .slv_req        (slv_req),
        .slv_req_vld    (slv_req_vld),
        .slv_req_rdy    (slv_req_rdy),
        .slv_rsp        (slv_rsp),
        .slv_ack_vld    (slv_ack_vld),
        .slv_ack_rdy    (slv_ack_rdy),
        .sync_reset     (sync_reset)
    );

    reg_addr_decoder dec0 (
        .clk            (clk),
        .rstn           (rstn),
        .slv_req        (slv_req),
        .slv_req_vld    (slv_req_vld),
        .slv_req_rdy    (slv_req_rdy),
        .slv_rsp        (slv_rsp),
        .slv_ack_vld    (slv_ack_vld),
        .slv_ack_rdy    (slv_ack_rdy),
        .sync_reset     (sync_reset),
        .int_req_vld    (int_req_vld),
        .int_req_rdy    (int_req_rdy),
        .int_ack_vld    (int_ack_vld),
        .int_ack_rdy    (int_ack_rdy),
        .int_rdata      (int_rdata),
        .ext_req        (ext_req),
        .ext_req_vld    (ext_req_vld),
        .ext_req_rdy    (ext_req_rdy),
        .ext_ack_vld    (ext_ack_vld),
        .ext_ack_rdy    (ext_ack_rdy),
        .ext_rdata      (ext_rdata),
        .ext_sync_reset (ext_sync_reset)
    );

    // internal file shares the latched request bus
    reg_int_file int0 (
        .clk        (clk),
        .rstn       (rstn),
        .sync_reset (sync_reset),
        .req        (slv_req),
        .req_vld    (int_req_vld),
        .req_rdy    (int_req_rdy),
        .ack_vld    (int_ack_vld),
        .ack_rdy    (int_ack_rdy),
        .rdata      (int_rdata)
    );

endmodule

`default_nettype wire

// File: logic/reg_slv_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module reg_slv_fsm (
    input  wire                        clk,
    input  wire                        rstn,
    // master side
    input  wire reg_bus_pkg::reg_req_t mst_req,
    input  wire                        mst_req_vld,
    output logic                       mst_req_rdy,
    output reg_bus_pkg::reg_rsp_t      mst_rsp,
    output logic                       mst_ack_vld,
    input  wire                        mst_ack_rdy,
    input  wire                        mst_sync_reset,
    // toward the decoder
    output reg_bus_pkg::reg_req_t      slv_req,
    output logic                       slv_req_vld,
    input  wire                        slv_req_rdy,
    input  wire reg_bus_pkg::reg_rsp_t slv_rsp,
    input  wire                        slv_ack_vld,
    output logic                       slv_ack_rdy,
    output logic                       sync_reset
);

    reg_bus_pkg::fsm_state_e state;
    reg_bus_pkg::fsm_state_e next_state;
    // request captured on master acceptance
    reg_bus_pkg::reg_req_t   req_q;
    logic                    mst_accept;
    logic                    slv_accept;
    logic                    ack_phase;
    logic                    ack_done;

    // handshake events
    assign mst_accept = mst_req_vld & mst_req_rdy;
    assign slv_accept = slv_req_vld & slv_req_rdy;

    // ack window, cancelled by a soft reset in the same cycle
    assign ack_phase = (state == reg_bus_pkg::S_WAIT_SLV_ACK) & ~mst_sync_reset;
    assign ack_done  = ack_phase & slv_ack_vld & mst_ack_rdy;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= reg_bus_pkg::S_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // next state
    always_comb begin
        next_state = state;
        case (state)
            reg_bus_pkg::S_IDLE: begin
                if (mst_accept) begin
                    next_state = reg_bus_pkg::S_WAIT_SLV_RDY;
                end
            end
            reg_bus_pkg::S_WAIT_SLV_RDY: begin
                // target took the request
                if (slv_accept) begin
                    next_state = reg_bus_pkg::S_WAIT_SLV_ACK;
                end
            end
            reg_bus_pkg::S_WAIT_SLV_ACK: begin
                // ack passed through to the master
                if (ack_done) begin
                    next_state = reg_bus_pkg::S_IDLE;
                end
            end
            default: begin
                next_state = reg_bus_pkg::S_IDLE;
            end
        endcase
        // soft reset wins from any state
        if (mst_sync_reset) begin
            next_state = reg_bus_pkg::S_IDLE;
        end
    end

    // registered handshake outputs, decoded from next state
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mst_req_rdy <= 1'b0;
            slv_req_vld <= 1'b0;
        end else begin
            mst_req_rdy <= (next_state == reg_bus_pkg::S_IDLE);
            // held until the target is seen ready
            slv_req_vld <= (next_state == reg_bus_pkg::S_WAIT_SLV_RDY);
        end
    end

    // request payload
    always_ff @(posedge clk) begin
        if (mst_accept) begin
            req_q <= mst_req;
        end
    end

    // bus is zero while idle
    assign slv_req = (state == reg_bus_pkg::S_IDLE) ? '0 : req_q;

    // ack path, combinational and gated by state
    assign mst_ack_vld = ack_phase & slv_ack_vld;
    assign slv_ack_rdy = ack_phase & mst_ack_rdy;
    assign mst_rsp     = mst_ack_vld ? slv_rsp : '0;

    // soft reset forwarded to every target
    assign sync_reset = mst_sync_reset;

endmodule

`default_nettype wire

// File: logic/reg_addr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "reg_bus_cfg.svh"

module reg_addr_decoder (
    input  wire                        clk,
    input  wire                        rstn,
    // from the FSM
    input  wire reg_bus_pkg::reg_req_t slv_req,
    input  wire                        slv_req_vld,
    output logic                       slv_req_rdy,
    output reg_bus_pkg::reg_rsp_t      slv_rsp,
    output logic                       slv_ack_vld,
    input  wire                        slv_ack_rdy,
    input  wire                        sync_reset,
    // internal register file
    output logic                       int_req_vld,
    input  wire                        int_req_rdy,
    input  wire                        int_ack_vld,
    output logic                       int_ack_rdy,
    input  wire [`REG_DATA_W-1:0]      int_rdata,
    // external blocks
    output reg_bus_pkg::reg_req_t      ext_req,
    output logic [`REG_NUM_EXT-1:0]    ext_req_vld,
    input  wire [`REG_NUM_EXT-1:0]     ext_req_rdy,
    input  wire [`REG_NUM_EXT-1:0]     ext_ack_vld,
    output logic [`REG_NUM_EXT-1:0]    ext_ack_rdy,
    input  wire [`REG_DATA_W-1:0]      ext_rdata [`REG_NUM_EXT],
    output logic                       ext_sync_reset
);

    localparam int TGT_W = `REG_ADDR_W - `REG_TGT_LSB;
    localparam int IDX_W = (`REG_NUM_EXT > 1) ? $clog2(`REG_NUM_EXT) : 1;

    logic [TGT_W-1:0]      tgt_field;
    logic [TGT_W-1:0]      ext_off;
    logic [IDX_W-1:0]      ext_idx;
    reg_bus_pkg::reg_tgt_e tgt;
    // error response pending for an unmapped address
    logic                  err_ack_q;

    // target field of the latched address
    assign tgt_field = slv_req.addr[`REG_ADDR_W-1:`REG_TGT_LSB];
    // external numbering starts at field value 1
    assign ext_off   = tgt_field - TGT_W'(1);
    assign ext_idx   = ext_off[IDX_W-1:0];

    always_comb begin
        if (tgt_field == '0) begin
            tgt = reg_bus_pkg::TGT_INT;
        end else if (tgt_field <= TGT_W'(`REG_NUM_EXT)) begin
            tgt = reg_bus_pkg::TGT_EXT;
        end else begin
            tgt = reg_bus_pkg::TGT_NONE;
        end
    end

    // only the selected target sees valid and ack ready
    assign int_req_vld = slv_req_vld & (tgt == reg_bus_pkg::TGT_INT);
    assign int_ack_rdy = slv_ack_rdy & (tgt == reg_bus_pkg::TGT_INT);

    always_comb begin
        for (int i = 0; i < `REG_NUM_EXT; i++) begin
            ext_req_vld[i] = slv_req_vld & (tgt == reg_bus_pkg::TGT_EXT)
                             & (ext_idx == IDX_W'(i));
            ext_ack_rdy[i] = slv_ack_rdy & (tgt == reg_bus_pkg::TGT_EXT)
                             & (ext_idx == IDX_W'(i));
        end
    end

    // one shared request bus for every external block
    assign ext_req        = slv_req;
    assign ext_sync_reset = sync_reset;

    // unmapped access: accept at once, ack with err next cycle
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            err_ack_q <= 1'b0;
        end else if (sync_reset) begin
            err_ack_q <= 1'b0;
        end else if (err_ack_q) begin
            // held until the FSM takes it
            err_ack_q <= ~slv_ack_rdy;
        end else if (slv_req_vld && tgt == reg_bus_pkg::TGT_NONE) begin
            err_ack_q <= 1'b1;
        end
    end

    // return path mux
    always_comb begin
        slv_req_rdy = 1'b0;
        slv_ack_vld = 1'b0;
        slv_rsp     = '0;
        case (tgt)
            reg_bus_pkg::TGT_INT: begin
                slv_req_rdy   = int_req_rdy;
                slv_ack_vld   = int_ack_vld;
                slv_rsp.rdata = int_rdata;
            end
            reg_bus_pkg::TGT_EXT: begin
                slv_req_rdy   = ext_req_rdy[ext_idx];
                slv_ack_vld   = ext_ack_vld[ext_idx];
                slv_rsp.rdata = ext_rdata[ext_idx];
            end
            default: begin
                // answered locally, rdata stays 0
                slv_req_rdy = ~err_ack_q;
                slv_ack_vld = err_ack_q;
                slv_rsp.err = err_ack_q;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: logic/reg_int_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "reg_bus_cfg.svh"

module reg_int_file (
    input  wire                        clk,
    input  wire                        rstn,
    input  wire                        sync_reset,
    input  wire reg_bus_pkg::reg_req_t req,
    input  wire                        req_vld,
    output logic                       req_rdy,
    output logic                       ack_vld,
    input  wire                        ack_rdy,
    output logic [`REG_DATA_W-1:0]     rdata
);

    localparam int IDX_W = (`REG_NUM_INT_REGS > 1) ? $clog2(`REG_NUM_INT_REGS) : 1;

    logic [`REG_DATA_W-1:0] regs [`REG_NUM_INT_REGS];
    logic [IDX_W-1:0]       idx;
    logic                   accept;
    logic                   is_write;

    // word index, byte bits dropped
    assign idx      = req.addr[`REG_WORD_LSB +: IDX_W];
    assign is_write = (req.op == reg_bus_pkg::OP_WRITE);

    // one access in flight, busy until the ack is taken
    assign req_rdy = ~ack_vld;
    assign accept  = req_vld & req_rdy & ~sync_reset;

    // word storage
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < `REG_NUM_INT_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (sync_reset) begin
            // soft reset clears every word
            for (int i = 0; i < `REG_NUM_INT_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (accept && is_write) begin
            regs[idx] <= req.wdata;
        end
    end

    // ack one cycle after acceptance, held until ack_rdy
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ack_vld <= 1'b0;
        end else if (sync_reset) begin
            ack_vld <= 1'b0;
        end else if (accept) begin
            ack_vld <= 1'b1;
        end else if (ack_rdy) begin
            ack_vld <= 1'b0;
        end
    end

    // response data, write echoes the written value
    always_ff @(posedge clk) begin
        if (accept) begin
            rdata <= is_write ? req.wdata : regs[idx];
        end
    end

endmodule

`default_nettype wire

// File: logic/reg_bus_pkg.sv
`default_nettype none

`include "reg_bus_cfg.svh"

package reg_bus_pkg;

    // access kind
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } reg_op_e;

    // request as issued by the master and latched by the FSM
    typedef struct packed {
        reg_op_e                op;
        logic [`REG_ADDR_W-1:0] addr;
        logic [`REG_DATA_W-1:0] wdata;
    } reg_req_t;

    // response returned with the ack
    typedef struct packed {
        logic [`REG_DATA_W-1:0] rdata;
        // set for unmapped addresses only
        logic                   err;
    } reg_rsp_t;

    // transaction FSM states
    typedef enum logic [1:0] {
        S_IDLE         = 2'd0,
        S_WAIT_SLV_RDY = 2'd1,
        S_WAIT_SLV_ACK = 2'd2
    } fsm_state_e;

    // decoded target kind
    typedef enum logic [1:0] {
        TGT_INT  = 2'd0,
        TGT_EXT  = 2'd1,
        TGT_NONE = 2'd2
    } reg_tgt_e;

endpackage

`default_nettype wire

// File: logic/reg_bus_cfg.svh
`ifndef REG_BUS_CFG_SVH
`define REG_BUS_CFG_SVH

// bus widths
`define REG_ADDR_W 16
`define REG_DATA_W 32

// depth of the internal register file
`define REG_NUM_INT_REGS 8

// external blocks reached through top-level ports
`define REG_NUM_EXT 2

// address map
// target field starts here
// 0 internal, 1..REG_NUM_EXT external, rest unmapped
`define REG_TGT_LSB 12

// word offset inside a target
// low two byte bits are dropped
`define REG_WORD_LSB 2

`endif
